//--- logic/i3c_dxt_params.svh
/* Table sizes and AXI address map of the DAT/DCT access subsystem.
   Include wherever table indices or the window bit are needed. */
`ifndef I3C_DXT_PARAMS_SVH
`define I3C_DXT_PARAMS_SVH

// DAT index width, 128 entries of 64 bits
`define DXT_DAT_AW 7

// DCT index width, 128 entries of 128 bits
`define DXT_DCT_AW 7

// Byte address width of the AXI4-Lite window
`define DXT_AXI_AW 13

// Address bit that picks the table, 0 for DAT and 1 for DCT
`define DXT_WIN_BIT 12

`endif

//--- logic/i3c_dxt_pkg.sv
/* Shared vector types and the AXI port state encoding.
   Referenced by scoped name from the RTL of the table subsystem. */
`default_nettype none

`include "i3c_dxt_params.svh"

package i3c_dxt_pkg;

  typedef logic [`DXT_AXI_AW-1:0] axi_addr_t;
  typedef logic [31:0]            csr_word_t;
  typedef logic [63:0]            dat_entry_t;
  typedef logic [127:0]           dct_entry_t;
  typedef logic [`DXT_DAT_AW-1:0] dat_index_t;
  typedef logic [`DXT_DCT_AW-1:0] dct_index_t;

  // AXI slave FSM
  typedef enum logic [2:0] {
    IDLE,
    WAIT_W,
    WAIT_AW,
    REQ,
    WAIT_ACK,
    RESP
  } port_state_e;

endpackage

`default_nettype wire

//--- logic/table_ram.sv
/* Single-port RAM with bitwise write mask and registered read data.
   Used for both the DAT and the DCT at different widths. */
`default_nettype none

module table_ram #(
  parameter int unsigned Width = 64,
  parameter int unsigned AddrW = 7
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             req_i,
  input  wire logic             we_i,
  input  wire logic [AddrW-1:0] addr_i,
  input  wire logic [Width-1:0] wdata_i,
  input  wire logic [Width-1:0] wmask_i,
  output logic      [Width-1:0] rdata_o
);

  logic [Width-1:0] mem_q [2**AddrW];

  // Only bits set in the mask take the new value
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- logic/axil_table_port.sv
/* AXI4-Lite slave for the table window, one transaction at a time.
   Turns each access into a DAT or DCT request and answers after the ack. */
`default_nettype none

`include "i3c_dxt_params.svh"

module axil_table_port (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // AXI4-Lite slave
  input  wire logic                   s_awvalid_i,
  output logic                        s_awready_o,
  input  wire i3c_dxt_pkg::axi_addr_t s_awaddr_i,
  input  wire logic                   s_wvalid_i,
  output logic                        s_wready_o,
  input  wire i3c_dxt_pkg::csr_word_t s_wdata_i,
  input  wire logic [3:0]             s_wstrb_i,
  output logic                        s_bvalid_o,
  input  wire logic                   s_bready_i,
  output logic [1:0]                  s_bresp_o,
  input  wire logic                   s_arvalid_i,
  output logic                        s_arready_o,
  input  wire i3c_dxt_pkg::axi_addr_t s_araddr_i,
  output logic                        s_rvalid_o,
  input  wire logic                   s_rready_i,
  output i3c_dxt_pkg::csr_word_t      s_rdata_o,
  output logic [1:0]                  s_rresp_o,
  // Table requests
  output logic                        dat_req_o,
  output logic                        dct_req_o,
  output logic                        req_is_wr_o,
  output i3c_dxt_pkg::axi_addr_t      req_addr_o,
  output i3c_dxt_pkg::csr_word_t      req_wdata_o,
  input  wire logic                   dat_rd_ack_i,
  input  wire logic                   dat_wr_ack_i,
  input  wire i3c_dxt_pkg::csr_word_t dat_rd_data_i,
  input  wire logic                   dct_rd_ack_i,
  input  wire logic                   dct_wr_ack_i,
  input  wire i3c_dxt_pkg::csr_word_t dct_rd_data_i
);

  i3c_dxt_pkg::port_state_e state_q, state_d;
  i3c_dxt_pkg::axi_addr_t   addr_q;
  i3c_dxt_pkg::csr_word_t   wdata_q;
  i3c_dxt_pkg::csr_word_t   rdata_q;
  logic                     is_wr_q;
  logic                     is_dct;
  logic                     aw_hs, w_hs, ar_hs;
  logic                     ack;

  assign is_dct = addr_q[`DXT_WIN_BIT];

  // A pending read keeps the write channels closed, so reads win ties
  assign s_arready_o = (state_q == i3c_dxt_pkg::IDLE);
  assign s_awready_o = (state_q == i3c_dxt_pkg::IDLE && !s_arvalid_i) ||
                       (state_q == i3c_dxt_pkg::WAIT_AW);
  assign s_wready_o  = (state_q == i3c_dxt_pkg::IDLE && !s_arvalid_i) ||
                       (state_q == i3c_dxt_pkg::WAIT_W);

  assign aw_hs = s_awvalid_i && s_awready_o;
  assign w_hs  = s_wvalid_i && s_wready_o;
  assign ar_hs = s_arvalid_i && s_arready_o;

  // Ack of the table that was addressed
  assign ack = is_dct ? (is_wr_q ? dct_wr_ack_i : dct_rd_ack_i)
                      : (is_wr_q ? dat_wr_ack_i : dat_rd_ack_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      i3c_dxt_pkg::IDLE: begin
        if (ar_hs || (aw_hs && w_hs)) begin
          state_d = i3c_dxt_pkg::REQ;
        end else if (aw_hs) begin
          state_d = i3c_dxt_pkg::WAIT_W;
        end else if (w_hs) begin
          state_d = i3c_dxt_pkg::WAIT_AW;
        end
      end
      i3c_dxt_pkg::WAIT_W:   if (w_hs) state_d = i3c_dxt_pkg::REQ;
      i3c_dxt_pkg::WAIT_AW:  if (aw_hs) state_d = i3c_dxt_pkg::REQ;
      i3c_dxt_pkg::REQ:      state_d = i3c_dxt_pkg::WAIT_ACK;
      i3c_dxt_pkg::WAIT_ACK: if (ack) state_d = i3c_dxt_pkg::RESP;
      i3c_dxt_pkg::RESP: begin
        if (is_wr_q ? s_bready_i : s_rready_i) begin
          state_d = i3c_dxt_pkg::IDLE;
        end
      end
      default: state_d = i3c_dxt_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i3c_dxt_pkg::IDLE;
      is_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ar_hs) begin
        is_wr_q <= 1'b0;
      end else if (aw_hs) begin
        is_wr_q <= 1'b1;
      end
    end
  end

  // Captured payload, WSTRB is not used since writes are full words
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      addr_q <= s_araddr_i;
    end else if (aw_hs) begin
      addr_q <= s_awaddr_i;
    end
    if (w_hs) begin
      wdata_q <= s_wdata_i;
    end
    if (state_q == i3c_dxt_pkg::WAIT_ACK && ack) begin
      rdata_q <= is_dct ? dct_rd_data_i : dat_rd_data_i;
    end
  end

  assign dat_req_o   = (state_q == i3c_dxt_pkg::REQ) && !is_dct;
  assign dct_req_o   = (state_q == i3c_dxt_pkg::REQ) && is_dct;
  assign req_is_wr_o = is_wr_q;
  assign req_addr_o  = addr_q;
  assign req_wdata_o = wdata_q;

  assign s_bvalid_o = (state_q == i3c_dxt_pkg::RESP) && is_wr_q;
  assign s_rvalid_o = (state_q == i3c_dxt_pkg::RESP) && !is_wr_q;
  // DCT is read-only from the bus side
  assign s_bresp_o  = is_dct ? 2'b10 : 2'b00;
  assign s_rresp_o  = 2'b00;
  assign s_rdata_o  = rdata_q;

  // Table acks only come back for the request in flight
  ack_only_when_waiting: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dat_rd_ack_i || dat_wr_ack_i || dct_rd_ack_i || dct_wr_ack_i)
      |-> state_q == i3c_dxt_pkg::WAIT_ACK);

endmodule

`default_nettype wire

//--- logic/dxt.sv
/* Access arbiter for the DAT and DCT RAMs.
   Controller accesses win; software words are deferred, merged and selected. */
`default_nettype none

`include "i3c_dxt_params.svh"

module dxt (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Software requests
  input  wire logic                    dat_req_i,
  input  wire logic                    dct_req_i,
  input  wire logic                    req_is_wr_i,
  input  wire i3c_dxt_pkg::axi_addr_t  req_addr_i,
  input  wire i3c_dxt_pkg::csr_word_t  req_wdata_i,
  output logic                         dat_rd_ack_o,
  output logic                         dat_wr_ack_o,
  output i3c_dxt_pkg::csr_word_t       dat_rd_data_o,
  output logic                         dct_rd_ack_o,
  output logic                         dct_wr_ack_o,
  output i3c_dxt_pkg::csr_word_t       dct_rd_data_o,
  // Controller
  input  wire logic                    dat_hw_rd_i,
  input  wire i3c_dxt_pkg::dat_index_t dat_hw_idx_i,
  output i3c_dxt_pkg::dat_entry_t      dat_hw_rdata_o,
  input  wire logic                    dct_hw_rd_i,
  input  wire logic                    dct_hw_wr_i,
  input  wire i3c_dxt_pkg::dct_index_t dct_hw_idx_i,
  input  wire i3c_dxt_pkg::dct_entry_t dct_hw_wdata_i,
  output i3c_dxt_pkg::dct_entry_t      dct_hw_rdata_o,
  // DAT RAM
  output logic                         dat_ram_req_o,
  output logic                         dat_ram_we_o,
  output i3c_dxt_pkg::dat_index_t      dat_ram_addr_o,
  output i3c_dxt_pkg::dat_entry_t      dat_ram_wdata_o,
  output i3c_dxt_pkg::dat_entry_t      dat_ram_wmask_o,
  input  wire i3c_dxt_pkg::dat_entry_t dat_ram_rdata_i,
  // DCT RAM
  output logic                         dct_ram_req_o,
  output logic                         dct_ram_we_o,
  output i3c_dxt_pkg::dct_index_t      dct_ram_addr_o,
  output i3c_dxt_pkg::dct_entry_t      dct_ram_wdata_o,
  output i3c_dxt_pkg::dct_entry_t      dct_ram_wmask_o,
  input  wire i3c_dxt_pkg::dct_entry_t dct_ram_rdata_i
);

  i3c_dxt_pkg::dat_index_t dat_sw_idx;
  i3c_dxt_pkg::dct_index_t dct_sw_idx;
  logic                    dat_word;
  logic [1:0]              dct_word;
  logic                    dat_pend_q, dct_pend_q;
  logic                    dat_sw_issue, dct_sw_issue;
  logic                    dct_hw_busy;
  logic                    dat_rd_s1_q, dat_wr_s1_q;
  logic                    dct_rd_s1_q, dct_wr_s1_q;

  // Two words per DAT entry, four per DCT entry
  assign dat_sw_idx = req_addr_i[`DXT_DAT_AW+2:3];
  assign dat_word   = req_addr_i[2];
  assign dct_sw_idx = req_addr_i[`DXT_DCT_AW+3:4];
  assign dct_word   = req_addr_i[3:2];

  // Port is single, so any controller access pushes software back
  assign dct_hw_busy  = dct_hw_rd_i || dct_hw_wr_i;
  assign dat_sw_issue = (dat_req_i || dat_pend_q) && !dat_hw_rd_i;
  assign dct_sw_issue = (dct_req_i || dct_pend_q) && !dct_hw_busy;

  // DAT port
  assign dat_ram_req_o   = dat_hw_rd_i || dat_sw_issue;
  assign dat_ram_we_o    = dat_sw_issue && req_is_wr_i;
  assign dat_ram_addr_o  = dat_hw_rd_i ? dat_hw_idx_i : dat_sw_idx;
  assign dat_ram_wdata_o = {req_wdata_i, req_wdata_i};
  // Upper word sits at byte offset 4
  assign dat_ram_wmask_o = {{32{dat_word}}, {32{!dat_word}}};
  assign dat_hw_rdata_o  = dat_ram_rdata_i;

  // DCT port, software writes never reach the RAM
  assign dct_ram_req_o   = dct_hw_busy || (dct_sw_issue && !req_is_wr_i);
  assign dct_ram_we_o    = dct_hw_wr_i;
  assign dct_ram_addr_o  = dct_hw_busy ? dct_hw_idx_i : dct_sw_idx;
  assign dct_ram_wdata_o = dct_hw_wdata_i;
  assign dct_ram_wmask_o = '1;
  assign dct_hw_rdata_o  = dct_ram_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dat_pend_q   <= 1'b0;
      dct_pend_q   <= 1'b0;
      dat_rd_s1_q  <= 1'b0;
      dat_wr_s1_q  <= 1'b0;
      dct_rd_s1_q  <= 1'b0;
      dct_wr_s1_q  <= 1'b0;
      dat_rd_ack_o <= 1'b0;
      dat_wr_ack_o <= 1'b0;
      dct_rd_ack_o <= 1'b0;
      dct_wr_ack_o <= 1'b0;
    end else begin
      // Held until a cycle free of controller traffic
      dat_pend_q   <= (dat_req_i || dat_pend_q) && dat_hw_rd_i;
      dct_pend_q   <= (dct_req_i || dct_pend_q) && dct_hw_busy;
      dat_rd_s1_q  <= dat_sw_issue && !req_is_wr_i;
      dat_wr_s1_q  <= dat_sw_issue && req_is_wr_i;
      dct_rd_s1_q  <= dct_sw_issue && !req_is_wr_i;
      // Acked anyway so the bus does not stall
      dct_wr_s1_q  <= dct_sw_issue && req_is_wr_i;
      dat_rd_ack_o <= dat_rd_s1_q;
      dat_wr_ack_o <= dat_wr_s1_q;
      dct_rd_ack_o <= dct_rd_s1_q;
      dct_wr_ack_o <= dct_wr_s1_q;
    end
  end

  // Word select from the RAM output, address is still held by the port
  always_ff @(posedge clk_i) begin
    if (dat_rd_s1_q) begin
      dat_rd_data_o <= dat_ram_rdata_i[{dat_word, 5'd0} +: 32];
    end
    if (dct_rd_s1_q) begin
      dct_rd_data_o <= dct_ram_rdata_i[{dct_word, 5'd0} +: 32];
    end
  end

  // A software DCT write leaves the RAM alone and is still acknowledged
  dct_sw_wr_acked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dct_sw_issue && req_is_wr_i |-> !dct_ram_we_o ##2 dct_wr_ack_o);

  // One transaction in flight, so read and write acks never meet
  acks_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((dat_rd_ack_o || dct_rd_ack_o) && (dat_wr_ack_o || dct_wr_ack_o)));

endmodule

`default_nettype wire

//--- logic/i3c_dxt_top.sv
/* Top of the DAT/DCT table subsystem for the I3C controller.
   Software uses the AXI4-Lite port, the controller the entry ports. */
`default_nettype none

`include "i3c_dxt_params.svh"

module i3c_dxt_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // AXI4-Lite slave
  input  wire logic                    s_awvalid_i,
  output logic                         s_awready_o,
  input  wire i3c_dxt_pkg::axi_addr_t  s_awaddr_i,
  input  wire logic                    s_wvalid_i,
  output logic                         s_wready_o,
  input  wire i3c_dxt_pkg::csr_word_t  s_wdata_i,
  input  wire logic [3:0]              s_wstrb_i,
  output logic                         s_bvalid_o,
  input  wire logic                    s_bready_i,
  output logic [1:0]                   s_bresp_o,
  input  wire logic                    s_arvalid_i,
  output logic                         s_arready_o,
  input  wire i3c_dxt_pkg::axi_addr_t  s_araddr_i,
  output logic                         s_rvalid_o,
  input  wire logic                    s_rready_i,
  output i3c_dxt_pkg::csr_word_t       s_rdata_o,
  output logic [1:0]                   s_rresp_o,
  // Controller
  input  wire logic                    dat_hw_rd_i,
  input  wire i3c_dxt_pkg::dat_index_t dat_hw_idx_i,
  output i3c_dxt_pkg::dat_entry_t      dat_hw_rdata_o,
  input  wire logic                    dct_hw_rd_i,
  input  wire logic                    dct_hw_wr_i,
  input  wire i3c_dxt_pkg::dct_index_t dct_hw_idx_i,
  input  wire i3c_dxt_pkg::dct_entry_t dct_hw_wdata_i,
  output i3c_dxt_pkg::dct_entry_t      dct_hw_rdata_o
);

  logic                    dat_req, dct_req, req_is_wr;
  i3c_dxt_pkg::axi_addr_t  req_addr;
  i3c_dxt_pkg::csr_word_t  req_wdata, dat_rd_data, dct_rd_data;
  logic                    dat_rd_ack, dat_wr_ack, dct_rd_ack, dct_wr_ack;
  logic                    dat_ram_req, dat_ram_we, dct_ram_req, dct_ram_we;
  i3c_dxt_pkg::dat_index_t dat_ram_addr;
  i3c_dxt_pkg::dct_index_t dct_ram_addr;
  i3c_dxt_pkg::dat_entry_t dat_ram_wdata, dat_ram_wmask, dat_ram_rdata;
  i3c_dxt_pkg::dct_entry_t dct_ram_wdata, dct_ram_wmask, dct_ram_rdata;

  axil_table_port u_port (
    .clk_i, .rst_ni,
    .s_awvalid_i, .s_awready_o, .s_awaddr_i,
    .s_wvalid_i, .s_wready_o, .s_wdata_i, .s_wstrb_i,
    .s_bvalid_o, .s_bready_i, .s_bresp_o,
    .s_arvalid_i, .s_arready_o, .s_araddr_i,
    .s_rvalid_o, .s_rready_i, .s_rdata_o, .s_rresp_o,
    .dat_req_o(dat_req), .dct_req_o(dct_req), .req_is_wr_o(req_is_wr),
    .req_addr_o(req_addr), .req_wdata_o(req_wdata),
    .dat_rd_ack_i(dat_rd_ack), .dat_wr_ack_i(dat_wr_ack), .dat_rd_data_i(dat_rd_data),
    .dct_rd_ack_i(dct_rd_ack), .dct_wr_ack_i(dct_wr_ack), .dct_rd_data_i(dct_rd_data)
  );

  dxt u_dxt (
    .clk_i, .rst_ni,
    .dat_req_i(dat_req), .dct_req_i(dct_req), .req_is_wr_i(req_is_wr),
    .req_addr_i(req_addr), .req_wdata_i(req_wdata),
    .dat_rd_ack_o(dat_rd_ack), .dat_wr_ack_o(dat_wr_ack), .dat_rd_data_o(dat_rd_data),
    .dct_rd_ack_o(dct_rd_ack), .dct_wr_ack_o(dct_wr_ack), .dct_rd_data_o(dct_rd_data),
    .dat_hw_rd_i, .dat_hw_idx_i, .dat_hw_rdata_o,
    .dct_hw_rd_i, .dct_hw_wr_i, .dct_hw_idx_i, .dct_hw_wdata_i, .dct_hw_rdata_o,
    .dat_ram_req_o(dat_ram_req), .dat_ram_we_o(dat_ram_we), .dat_ram_addr_o(dat_ram_addr),
    .dat_ram_wdata_o(dat_ram_wdata), .dat_ram_wmask_o(dat_ram_wmask),
    .dat_ram_rdata_i(dat_ram_rdata),
    .dct_ram_req_o(dct_ram_req), .dct_ram_we_o(dct_ram_we), .dct_ram_addr_o(dct_ram_addr),
    .dct_ram_wdata_o(dct_ram_wdata), .dct_ram_wmask_o(dct_ram_wmask),
    .dct_ram_rdata_i(dct_ram_rdata)
  );

  // 64-bit DAT entries
  table_ram #(.Width(64), .AddrW(`DXT_DAT_AW)) u_dat_ram (
    .clk_i, .rst_ni,
    .req_i(dat_ram_req), .we_i(dat_ram_we), .addr_i(dat_ram_addr),
    .wdata_i(dat_ram_wdata), .wmask_i(dat_ram_wmask), .rdata_o(dat_ram_rdata)
  );

  // 128-bit DCT entries
  table_ram #(.Width(128), .AddrW(`DXT_DCT_AW)) u_dct_ram (
    .clk_i, .rst_ni,
    .req_i(dct_ram_req), .we_i(dct_ram_we), .addr_i(dct_ram_addr),
    .wdata_i(dct_ram_wdata), .wmask_i(dct_ram_wmask), .rdata_o(dct_ram_rdata)
  );

endmodule

`default_nettype wire

//--- tests/tb_i3c_dxt.sv
/* Table-driven testbench for the DAT/DCT subsystem.
   Rows run in order over AXI and the controller ports against two model tables. */
`default_nettype none

`include "i3c_dxt_params.svh"

module tb_i3c_dxt;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum int {AXI_WR, AXI_RD, DAT_RD, DCT_WR, DCT_RD} op_e;

  logic         clk_i = 1'b0;
  logic         rst_ni = 1'b0;
  logic         s_awvalid_i = 1'b0, s_wvalid_i = 1'b0, s_bready_i = 1'b0;
  logic         s_arvalid_i = 1'b0, s_rready_i = 1'b0;
  logic [12:0]  s_awaddr_i = '0, s_araddr_i = '0;
  logic [31:0]  s_wdata_i = '0;
  logic [3:0]   s_wstrb_i = 4'hf;
  logic         dat_hw_rd_i = 1'b0, dct_hw_rd_i = 1'b0, dct_hw_wr_i = 1'b0;
  logic [6:0]   dat_hw_idx_i = '0, dct_hw_idx_i = '0;
  logic [127:0] dct_hw_wdata_i = '0;
  logic         s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
  logic [1:0]   s_bresp_o, s_rresp_o;
  logic [31:0]  s_rdata_o;
  logic [63:0]  dat_hw_rdata_o;
  logic [127:0] dct_hw_rdata_o;

  // Stimulus table, one row per slot of the queues
  op_e          row_op[$];
  logic [12:0]  row_addr[$];
  logic [127:0] row_data[$], row_want[$];
  bit           row_rnd[$];
  int           row_stall[$], row_busy[$];

  // Reference copies of both tables
  logic [63:0]  dat_model [128];
  logic [127:0] dct_model [128];
  logic [31:0]  seed = 32'd10;
  int           errors = 0;
  int           cycles = 0;

  i3c_dxt_top dut (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 20 * row_op.size() + 4) begin
      $display("Timeout: run did not finish within %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // Word seen by software, DAT upper word at offset 4, DCT lowest word first
  function automatic logic [31:0] model_word(input logic [12:0] addr);
    if (addr[`DXT_WIN_BIT]) begin
      return dct_model[addr[10:4]][addr[3:2]*32 +: 32];
    end
    return dat_model[addr[9:3]][addr[2]*32 +: 32];
  endfunction

  task automatic check_val(input string name, input logic [127:0] want,
                           input logic [127:0] got);
    assert (got === want) else begin
      $display("ERR %s exp %0h got %0h", name, want, got);
      errors++;
    end
  endtask

  // Address and data channels stay closed while a response waits
  task automatic check_readies_low();
    check_val("s_awready_o", 128'h0, {127'h0, s_awready_o});
    check_val("s_wready_o", 128'h0, {127'h0, s_wready_o});
    check_val("s_arready_o", 128'h0, {127'h0, s_arready_o});
  endtask

  task automatic add_row(input op_e op, input logic [12:0] addr, input logic [127:0] data,
                         input logic [127:0] want, input bit rnd, input int stall,
                         input int busy);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_want.push_back(want);
    row_rnd.push_back(rnd);
    row_stall.push_back(stall);
    row_busy.push_back(busy);
  endtask

  task automatic write_word(input logic [12:0] addr, input logic [31:0] data,
                            input int stall, output logic [1:0] resp);
    bit aw_done, w_done;
    @(negedge clk_i);
    s_awvalid_i = 1'b1;
    s_awaddr_i = addr;
    s_wvalid_i = 1'b1;
    s_wdata_i = data;
    // AW and W may complete on different edges
    while (s_awvalid_i || s_wvalid_i) begin
      aw_done = s_awvalid_i && s_awready_o;
      w_done = s_wvalid_i && s_wready_o;
      @(negedge clk_i);
      if (aw_done) s_awvalid_i = 1'b0;
      if (w_done) s_wvalid_i = 1'b0;
    end
    while (!s_bvalid_o) @(negedge clk_i);
    resp = s_bresp_o;
    check_readies_low();
    repeat (stall) begin
      @(negedge clk_i);
      assert (s_bvalid_o) else begin
        $display("BVALID dropped while BREADY was low");
        errors++;
      end
      check_val("s_bresp_o", {126'h0, resp}, {126'h0, s_bresp_o});
    end
    s_bready_i = 1'b1;
    @(negedge clk_i);
    s_bready_i = 1'b0;
  endtask

  task automatic read_word(input logic [12:0] addr, input int stall,
                           output logic [31:0] data);
    @(negedge clk_i);
    s_arvalid_i = 1'b1;
    s_araddr_i = addr;
    while (!s_arready_o) @(negedge clk_i);
    @(negedge clk_i);
    s_arvalid_i = 1'b0;
    while (!s_rvalid_o) @(negedge clk_i);
    data = s_rdata_o;
    check_val("s_rresp_o", 128'h0, {126'h0, s_rresp_o});
    check_readies_low();
    repeat (stall) begin
      @(negedge clk_i);
      assert (s_rvalid_o) else begin
        $display("RVALID dropped while RREADY was low");
        errors++;
      end
      check_val("s_rdata_o", {96'h0, data}, {96'h0, s_rdata_o});
    end
    s_rready_i = 1'b1;
    @(negedge clk_i);
    s_rready_i = 1'b0;
  endtask

  // Controller reads one DAT entry every cycle, pushing software back
  task automatic hold_dat_read(input logic [6:0] idx, input int busy);
    if (busy > 0) begin
      @(negedge clk_i);
      dat_hw_rd_i = 1'b1;
      dat_hw_idx_i = idx;
      repeat (busy) begin
        @(negedge clk_i);
        check_val("dat_hw_rdata_o", {64'h0, dat_model[idx]}, {64'h0, dat_hw_rdata_o});
      end
      dat_hw_rd_i = 1'b0;
    end
  endtask

  task automatic run_row(input int i);
    logic [127:0] data, want;
    logic [31:0]  word;
    logic [1:0]   resp;
    int           errs_before;
    errs_before = errors;
    data = row_data[i];
    want = row_want[i];
    case (row_op[i])
      AXI_WR: begin
        if (row_rnd[i]) data = {96'h0, next_rand()};
        write_word(row_addr[i], data[31:0], row_stall[i], resp);
        check_val("s_bresp_o", want, {126'h0, resp});
        // Software writes into the DCT window change nothing
        if (!row_addr[i][`DXT_WIN_BIT]) begin
          dat_model[row_addr[i][9:3]][row_addr[i][2]*32 +: 32] = data[31:0];
        end
      end
      AXI_RD: begin
        if (row_rnd[i]) want = {96'h0, model_word(row_addr[i])};
        fork
          read_word(row_addr[i], row_stall[i], word);
          hold_dat_read(row_addr[i][9:3], row_busy[i]);
        join
        check_val("s_rdata_o", want, {96'h0, word});
      end
      DAT_RD: begin
        if (row_rnd[i]) want = {64'h0, dat_model[row_addr[i][6:0]]};
        @(negedge clk_i);
        dat_hw_rd_i = 1'b1;
        dat_hw_idx_i = row_addr[i][6:0];
        @(negedge clk_i);
        dat_hw_rd_i = 1'b0;
        check_val("dat_hw_rdata_o", want, {64'h0, dat_hw_rdata_o});
      end
      DCT_WR: begin
        if (row_rnd[i]) data = {next_rand(), next_rand(), next_rand(), next_rand()};
        @(negedge clk_i);
        dct_hw_wr_i = 1'b1;
        dct_hw_idx_i = row_addr[i][6:0];
        dct_hw_wdata_i = data;
        @(negedge clk_i);
        dct_hw_wr_i = 1'b0;
        dct_model[row_addr[i][6:0]] = data;
      end
      default: begin
        if (row_rnd[i]) want = dct_model[row_addr[i][6:0]];
        @(negedge clk_i);
        dct_hw_rd_i = 1'b1;
        dct_hw_idx_i = row_addr[i][6:0];
        @(negedge clk_i);
        dct_hw_rd_i = 1'b0;
        check_val("dct_hw_rdata_o", want, dct_hw_rdata_o);
      end
    endcase
    $display("test %0d %s addr %h: %s", i, row_op[i].name(), row_addr[i],
             (errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    // Known DAT words, then one upper word rewritten alone
    add_row(AXI_WR, 13'h010, 128'h11223344, 128'h0, 1'b0, 0, 0);
    add_row(AXI_WR, 13'h014, 128'h55667788, 128'h0, 1'b0, 0, 0);
    add_row(AXI_RD, 13'h010, 128'h0, 128'h11223344, 1'b0, 0, 0);
    add_row(AXI_RD, 13'h014, 128'h0, 128'h55667788, 1'b0, 0, 0);
    add_row(DAT_RD, 13'd2, 128'h0, 128'h55667788_11223344, 1'b0, 0, 0);
    add_row(AXI_WR, 13'h014, 128'hcafef00d, 128'h0, 1'b0, 0, 0);
    add_row(AXI_RD, 13'h010, 128'h0, 128'h11223344, 1'b0, 0, 0);
    add_row(DAT_RD, 13'd2, 128'h0, 128'hcafef00d_11223344, 1'b0, 0, 0);
    // DCT entry from the controller, read back word by word
    add_row(DCT_WR, 13'd5, 128'h0f0e0d0c_0b0a0908_07060504_03020100, 128'h0, 1'b0, 0, 0);
    add_row(AXI_RD, 13'h1050, 128'h0, 128'h03020100, 1'b0, 0, 0);
    add_row(AXI_RD, 13'h1054, 128'h0, 128'h07060504, 1'b0, 0, 0);
    add_row(AXI_RD, 13'h1058, 128'h0, 128'h0b0a0908, 1'b0, 0, 0);
    add_row(AXI_RD, 13'h105c, 128'h0, 128'h0f0e0d0c, 1'b0, 0, 0);
    add_row(AXI_WR, 13'h1054, 128'hdeadbeef, 128'h2, 1'b0, 0, 0);
    add_row(DCT_RD, 13'd5, 128'h0, 128'h0f0e0d0c_0b0a0908_07060504_03020100, 1'b0, 0, 0);
    // Random data, controller collisions and back-pressure
    add_row(AXI_WR, 13'h020, 128'h0, 128'h0, 1'b1, 0, 0);
    add_row(AXI_WR, 13'h024, 128'h0, 128'h0, 1'b1, 0, 0);
    add_row(AXI_RD, 13'h024, 128'h0, 128'h0, 1'b1, 0, 6);
    add_row(AXI_RD, 13'h020, 128'h0, 128'h0, 1'b1, 5, 0);
    add_row(DAT_RD, 13'd4, 128'h0, 128'h0, 1'b1, 0, 0);
    add_row(AXI_WR, 13'h1000, 128'h0, 128'h2, 1'b1, 3, 0);
    add_row(DCT_WR, 13'd9, 128'h0, 128'h0, 1'b1, 0, 0);
    add_row(AXI_RD, 13'h1098, 128'h0, 128'h0, 1'b1, 2, 0);
    add_row(DCT_RD, 13'd9, 128'h0, 128'h0, 1'b1, 0, 0);

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < row_op.size(); i++) begin
      run_row(i);
    end

    $display("tests %0d, errors %0d", row_op.size(), errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/i3c_dxt_pkg.sv
logic/table_ram.sv
logic/axil_table_port.sv
logic/dxt.sv
logic/i3c_dxt_top.sv
tests/tb_i3c_dxt.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and look for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f verilog.f \
  --top-module tb_i3c_dxt -o sim_tb || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_tb)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" || {
  echo "simulation failed"; exit 1; }
